// File: rtl/l15_bridge_pkg.sv
package l15_bridge_pkg;

    // address and data widths
    localparam int PADDR_W = 40;
    localparam int DATA_W = 64;
    localparam int NUM_CHAN = 3;

    // instruction cache geometry
    localparam int IC_OFFSET_W = 5;
    localparam int IC_INDEX_W = 7;
    localparam int IC_TAG_W = PADDR_W - IC_OFFSET_W - IC_INDEX_W;
    localparam int IC_LINE_W = 256;
    localparam int IC_BLK_W = PADDR_W - IC_OFFSET_W;

    // data cache geometry
    localparam int DC_OFFSET_W = 4;
    localparam int DC_INDEX_W = 8;
    localparam int DC_TAG_W = PADDR_W - DC_OFFSET_W - DC_INDEX_W;
    localparam int DC_LINE_W = 128;
    localparam int DC_BLK_W = PADDR_W - DC_OFFSET_W;

    // lower index wins arbitration
    typedef enum logic [1:0] {
        CH_IMISS = 2'd0,
        CH_LOAD  = 2'd1,
        CH_STORE = 2'd2
    } chan_e;

    typedef enum logic [1:0] {
        EMPTY   = 2'd0,
        PENDING = 2'd1,
        ISSUED  = 2'd2
    } slot_state_e;

    // L1.5 request opcodes
    typedef enum logic [4:0] {
        LOAD_RQ  = 5'b00000,
        STORE_RQ = 5'b00001,
        SWAP_RQ  = 5'b00110,
        IMISS_RQ = 5'b10000
    } rqtype_e;

    typedef enum logic [3:0] {
        AMO_NONE = 4'b0000,
        AMO_LR   = 4'b0001,
        AMO_SC   = 4'b0010
    } amo_op_e;

    typedef enum logic [3:0] {
        LOAD_RET   = 4'b0000,
        IFILL_RET  = 4'b0001,
        ST_ACK     = 4'b0100,
        INT_RET    = 4'b0111,
        ATOMIC_RET = 4'b1110
    } rettype_e;

    typedef enum logic [2:0] {
        SZ_1B  = 3'b000,
        SZ_2B  = 3'b001,
        SZ_4B  = 3'b010,
        SZ_8B  = 3'b011,
        SZ_16B = 3'b111
    } size_e;

    typedef struct packed {
        logic [PADDR_W-1:0] addr;
        logic [DATA_W-1:0]  data;
        size_e              size;
        rqtype_e            rqtype;
        amo_op_e            amo_op;
        logic [1:0]         way;
    } chan_req_t;

    typedef struct packed {
        logic                         val;
        rettype_e                     rettype;
        logic [PADDR_W-1:0]           addr;
        logic [3:0][DATA_W-1:0]       data;
    } l15_ret_t;

    typedef struct packed {
        logic                  valid;
        logic [IC_TAG_W-1:0]   tag;
        logic [IC_INDEX_W-1:0] index;
        logic [IC_LINE_W-1:0]  line;
    } ic_fill_t;

    typedef struct packed {
        logic                  valid;
        logic [DC_TAG_W-1:0]   tag;
        logic [DC_INDEX_W-1:0] index;
        logic [DC_LINE_W-1:0]  line;
    } dc_fill_t;

    // core and L1.5 disagree on byte order within a word
    function automatic logic [DATA_W-1:0] bswap(input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] r;
        for (int b = 0; b < DATA_W / 8; b++) begin
            r[8*b +: 8] = d[DATA_W-8-8*b +: 8];
        end
        return r;
    endfunction

endpackage

// File: rtl/req_capture.sv
`timescale 1ns/100ps

module req_capture import l15_bridge_pkg::*; (
    input  logic [IC_BLK_W-1:0]       ic_req_addr_i,
    input  logic                      ic_req_valid_i,
    input  logic [DC_BLK_W-1:0]       dc_ld_addr_i,
    input  logic                      dc_ld_reserve_i,
    input  logic                      dc_ld_valid_i,
    input  logic [PADDR_W-1:0]        dc_st_addr_i,
    input  logic [DATA_W-1:0]         dc_st_data_i,
    input  size_e                     dc_st_size_i,
    input  logic                      dc_st_cond_i,
    input  logic                      dc_st_valid_i,
    output chan_req_t [NUM_CHAN-1:0]  chan_req_o,
    output logic [NUM_CHAN-1:0]       chan_load_o
);

    always_comb begin
        chan_req_o = '0;

        // instruction fill widens the block address back to bytes
        chan_req_o[CH_IMISS].addr   = {ic_req_addr_i, {IC_OFFSET_W{1'b0}}};
        chan_req_o[CH_IMISS].data   = '0;
        chan_req_o[CH_IMISS].size   = SZ_4B;
        chan_req_o[CH_IMISS].rqtype = IMISS_RQ;
        chan_req_o[CH_IMISS].amo_op = AMO_NONE;
        chan_req_o[CH_IMISS].way    = ic_req_addr_i[IC_INDEX_W-1 -: 2];

        // reserved loads go out as atomics
        chan_req_o[CH_LOAD].addr   = {dc_ld_addr_i, {DC_OFFSET_W{1'b0}}};
        chan_req_o[CH_LOAD].data   = '0;
        chan_req_o[CH_LOAD].size   = SZ_16B;
        chan_req_o[CH_LOAD].rqtype = dc_ld_reserve_i ? SWAP_RQ : LOAD_RQ;
        chan_req_o[CH_LOAD].amo_op = dc_ld_reserve_i ? AMO_LR : AMO_NONE;
        chan_req_o[CH_LOAD].way    = dc_ld_addr_i[DC_INDEX_W-1 -: 2];

        // store already carries a byte address
        chan_req_o[CH_STORE].addr   = dc_st_addr_i;
        chan_req_o[CH_STORE].data   = bswap(dc_st_data_i);
        chan_req_o[CH_STORE].size   = dc_st_size_i;
        chan_req_o[CH_STORE].rqtype = dc_st_cond_i ? SWAP_RQ : STORE_RQ;
        chan_req_o[CH_STORE].amo_op = dc_st_cond_i ? AMO_SC : AMO_NONE;
        chan_req_o[CH_STORE].way    = dc_st_addr_i[DC_OFFSET_W+DC_INDEX_W-1 -: 2];
    end

    always_comb begin
        chan_load_o = '0;
        chan_load_o[CH_IMISS] = ic_req_valid_i;
        chan_load_o[CH_LOAD]  = dc_ld_valid_i;
        chan_load_o[CH_STORE] = dc_st_valid_i;
    end

endmodule

// File: rtl/req_slot.sv
`timescale 1ns/100ps

module req_slot import l15_bridge_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  chan_req_t req_i,
    input  logic      load_i,
    input  logic      grant_i,
    input  logic      done_i,
    output chan_req_t req_o,
    output logic      pending_o,
    output amo_op_e   held_amo_o
);

    slot_state_e state_q;
    chan_req_t   req_q;
    amo_op_e     amo_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= EMPTY;
        end else begin
            case (state_q)
                EMPTY: begin
                    if (load_i) begin
                        state_q <= PENDING;
                    end
                end
                PENDING: begin
                    if (grant_i) begin
                        state_q <= ISSUED;
                    end
                end
                ISSUED: begin
                    if (done_i) begin
                        state_q <= EMPTY;
                    end
                end
                default: state_q <= EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            req_q <= req_i;
        end
    end

    // last request's operation stays past the ack for return steering
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            amo_q <= AMO_NONE;
        end else if (load_i) begin
            amo_q <= req_i.amo_op;
        end
    end

    assign req_o      = req_q;
    assign pending_o  = (state_q == PENDING);
    assign held_amo_o = amo_q;

    // core may not reuse a channel while the L1.5 still owns its request
    a_no_load_when_issued: assert property (
        @(posedge clk) disable iff (!rst_n) (state_q == ISSUED) |-> !load_i
    );

    // issue side must only grant what this slot advertised
    a_grant_only_pending: assert property (
        @(posedge clk) disable iff (!rst_n) grant_i |-> (state_q == PENDING)
    );

endmodule

// File: rtl/req_issue.sv
`timescale 1ns/100ps

module req_issue import l15_bridge_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  chan_req_t [NUM_CHAN-1:0]  slot_req_i,
    input  logic [NUM_CHAN-1:0]       slot_pending_i,
    input  logic                      l15_ack_i,
    output logic [NUM_CHAN-1:0]       grant_o,
    output logic [NUM_CHAN-1:0]       done_o,
    output chan_req_t                 l15_req_o,
    output logic                      l15_req_val_o,
    output logic                      l15_nc_o
);

    logic      val_q;
    chan_e     owner_q;
    chan_req_t req_q;
    logic      sel_valid;
    chan_e     sel_idx;
    logic      take;

    // fixed priority with the lowest channel index first
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = CH_IMISS;
        for (int k = NUM_CHAN - 1; k >= 0; k--) begin
            if (slot_pending_i[k]) begin
                sel_valid = 1'b1;
                sel_idx   = chan_e'(k);
            end
        end
    end

    // only one request outstanding at the L1.5
    assign take = !val_q && sel_valid;

    always_comb begin
        grant_o = '0;
        if (take) begin
            grant_o[sel_idx] = 1'b1;
        end
    end

    always_comb begin
        done_o = '0;
        if (val_q && l15_ack_i) begin
            done_o[owner_q] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            val_q   <= 1'b0;
            owner_q <= CH_IMISS;
        end else if (val_q && l15_ack_i) begin
            val_q <= 1'b0;
        end else if (take) begin
            val_q   <= 1'b1;
            owner_q <= sel_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req_q <= slot_req_i[sel_idx];
        end
    end

    assign l15_req_o     = req_q;
    assign l15_req_val_o = val_q;
    // top address bit marks non-cacheable space
    assign l15_nc_o      = req_q.addr[PADDR_W-1];

    // request must hold until the L1.5 takes it
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (l15_req_val_o && !l15_ack_i) |=> (l15_req_val_o && $stable(l15_req_o))
    );

endmodule

// File: rtl/resp_decode.sv
`timescale 1ns/100ps

module resp_decode import l15_bridge_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  l15_ret_t l15_ret_i,
    input  amo_op_e  ld_amo_i,
    input  logic     dc_st_valid_i,
    output ic_fill_t ic_fill_o,
    output dc_fill_t dc_fill_o,
    output logic     dc_st_complete_o,
    output logic     dc_st_stall_o,
    output logic     int_o
);

    logic ic_hit;
    logic dc_hit;
    logic int_hit;
    logic st_busy_q;

    always_comb begin
        ic_hit           = 1'b0;
        dc_hit           = 1'b0;
        dc_st_complete_o = 1'b0;
        int_hit          = 1'b0;
        if (l15_ret_i.val) begin
            case (l15_ret_i.rettype)
                IFILL_RET: ic_hit = 1'b1;
                LOAD_RET:  dc_hit = 1'b1;
                ST_ACK:    dc_st_complete_o = 1'b1;
                INT_RET:   int_hit = 1'b1;
                ATOMIC_RET: begin
                    // LR returns a line, SC only completes the store
                    if (ld_amo_i == AMO_LR) begin
                        dc_hit = 1'b1;
                    end else begin
                        dc_st_complete_o = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        ic_fill_o.valid = ic_hit;
        ic_fill_o.tag   = l15_ret_i.addr[PADDR_W-1 -: IC_TAG_W];
        ic_fill_o.index = l15_ret_i.addr[IC_OFFSET_W +: IC_INDEX_W];
        ic_fill_o.line  = {bswap(l15_ret_i.data[3]), bswap(l15_ret_i.data[2]),
                           bswap(l15_ret_i.data[1]), bswap(l15_ret_i.data[0])};

        // data line is the low two words only
        dc_fill_o.valid = dc_hit;
        dc_fill_o.tag   = l15_ret_i.addr[PADDR_W-1 -: DC_TAG_W];
        dc_fill_o.index = l15_ret_i.addr[DC_OFFSET_W +: DC_INDEX_W];
        dc_fill_o.line  = {bswap(l15_ret_i.data[1]), bswap(l15_ret_i.data[0])};
    end

    // store in flight until its completion return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            st_busy_q <= 1'b0;
        end else if (dc_st_valid_i) begin
            st_busy_q <= 1'b1;
        end else if (dc_st_complete_o) begin
            st_busy_q <= 1'b0;
        end
    end

    assign dc_st_stall_o = st_busy_q | dc_st_valid_i;

    // wakeup pulse one cycle after the return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            int_o <= 1'b0;
        end else begin
            int_o <= int_hit;
        end
    end

endmodule

// File: rtl/l15_bridge_top.sv
`timescale 1ns/100ps

module l15_bridge_top import l15_bridge_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [IC_BLK_W-1:0] ic_req_addr_i,
    input  logic                ic_req_valid_i,
    input  logic [DC_BLK_W-1:0] dc_ld_addr_i,
    input  logic                dc_ld_reserve_i,
    input  logic                dc_ld_valid_i,
    input  logic [PADDR_W-1:0]  dc_st_addr_i,
    input  logic [DATA_W-1:0]   dc_st_data_i,
    input  size_e               dc_st_size_i,
    input  logic                dc_st_cond_i,
    input  logic                dc_st_valid_i,
    input  logic                l15_ack_i,
    input  l15_ret_t            l15_ret_i,
    output chan_req_t           l15_req_o,
    output logic                l15_req_val_o,
    output logic                l15_nc_o,
    output logic                l15_ret_ack_o,
    output ic_fill_t            ic_fill_o,
    output dc_fill_t            dc_fill_o,
    output logic                dc_st_complete_o,
    output logic                dc_st_stall_o,
    output logic                int_o
);

    chan_req_t [NUM_CHAN-1:0] cap_req;
    logic [NUM_CHAN-1:0]      cap_load;
    chan_req_t [NUM_CHAN-1:0] slot_req;
    logic [NUM_CHAN-1:0]      slot_pending;
    amo_op_e                  slot_amo [NUM_CHAN];
    logic [NUM_CHAN-1:0]      grant;
    logic [NUM_CHAN-1:0]      done;

    req_capture req_capture_i (
        .ic_req_addr_i   (ic_req_addr_i),
        .ic_req_valid_i  (ic_req_valid_i),
        .dc_ld_addr_i    (dc_ld_addr_i),
        .dc_ld_reserve_i (dc_ld_reserve_i),
        .dc_ld_valid_i   (dc_ld_valid_i),
        .dc_st_addr_i    (dc_st_addr_i),
        .dc_st_data_i    (dc_st_data_i),
        .dc_st_size_i    (dc_st_size_i),
        .dc_st_cond_i    (dc_st_cond_i),
        .dc_st_valid_i   (dc_st_valid_i),
        .chan_req_o      (cap_req),
        .chan_load_o     (cap_load)
    );

    // one holding slot per channel
    for (genvar k = 0; k < NUM_CHAN; k++) begin : g_slot
        req_slot req_slot_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .req_i      (cap_req[k]),
            .load_i     (cap_load[k]),
            .grant_i    (grant[k]),
            .done_i     (done[k]),
            .req_o      (slot_req[k]),
            .pending_o  (slot_pending[k]),
            .held_amo_o (slot_amo[k])
        );
    end

    req_issue req_issue_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .slot_req_i     (slot_req),
        .slot_pending_i (slot_pending),
        .l15_ack_i      (l15_ack_i),
        .grant_o        (grant),
        .done_o         (done),
        .l15_req_o      (l15_req_o),
        .l15_req_val_o  (l15_req_val_o),
        .l15_nc_o       (l15_nc_o)
    );

    resp_decode resp_decode_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .l15_ret_i        (l15_ret_i),
        .ld_amo_i         (slot_amo[CH_LOAD]),
        .dc_st_valid_i    (dc_st_valid_i),
        .ic_fill_o        (ic_fill_o),
        .dc_fill_o        (dc_fill_o),
        .dc_st_complete_o (dc_st_complete_o),
        .dc_st_stall_o    (dc_st_stall_o),
        .int_o            (int_o)
    );

    // every return is accepted in its own cycle
    assign l15_ret_ack_o = l15_ret_i.val;

endmodule

// File: tests/tb_l15_bridge.sv
`timescale 1ns/100ps

module tb_l15_bridge import l15_bridge_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 200;
    localparam int REQ_WAIT_MAX = 20;
    localparam int CW           = 320;

    logic                clk;
    logic                rst_n;
    logic [IC_BLK_W-1:0] ic_req_addr_i;
    logic                ic_req_valid_i;
    logic [DC_BLK_W-1:0] dc_ld_addr_i;
    logic                dc_ld_reserve_i;
    logic                dc_ld_valid_i;
    logic [PADDR_W-1:0]  dc_st_addr_i;
    logic [DATA_W-1:0]   dc_st_data_i;
    size_e               dc_st_size_i;
    logic                dc_st_cond_i;
    logic                dc_st_valid_i;
    logic                l15_ack_i;
    l15_ret_t            l15_ret_i;
    chan_req_t           l15_req_o;
    logic                l15_req_val_o;
    logic                l15_nc_o;
    logic                l15_ret_ack_o;
    ic_fill_t            ic_fill_o;
    dc_fill_t            dc_fill_o;
    logic                dc_st_complete_o;
    logic                dc_st_stall_o;
    logic                int_o;

    integer seed;
    int     errors;
    int     checks;

    l15_bridge_top l15_bridge_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .ic_req_addr_i    (ic_req_addr_i),
        .ic_req_valid_i   (ic_req_valid_i),
        .dc_ld_addr_i     (dc_ld_addr_i),
        .dc_ld_reserve_i  (dc_ld_reserve_i),
        .dc_ld_valid_i    (dc_ld_valid_i),
        .dc_st_addr_i     (dc_st_addr_i),
        .dc_st_data_i     (dc_st_data_i),
        .dc_st_size_i     (dc_st_size_i),
        .dc_st_cond_i     (dc_st_cond_i),
        .dc_st_valid_i    (dc_st_valid_i),
        .l15_ack_i        (l15_ack_i),
        .l15_ret_i        (l15_ret_i),
        .l15_req_o        (l15_req_o),
        .l15_req_val_o    (l15_req_val_o),
        .l15_nc_o         (l15_nc_o),
        .l15_ret_ack_o    (l15_ret_ack_o),
        .ic_fill_o        (ic_fill_o),
        .dc_fill_o        (dc_fill_o),
        .dc_st_complete_o (dc_st_complete_o),
        .dc_st_stall_o    (dc_st_stall_o),
        .int_o            (int_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    task automatic check_vec(input string test, input string what,
                             input logic [CW-1:0] exp, input logic [CW-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string test, input string what,
                             input logic exp, input logic act);
        check_vec(test, what, CW'(exp), CW'(act));
    endtask

    // L1.5 side expects the opposite byte order within a word
    function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] w);
        logic [DATA_W-1:0] r;
        r = {<<8{w}};
        return r;
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic chan_req_t make_req(input logic [PADDR_W-1:0] addr,
                                           input logic [DATA_W-1:0] data, input size_e size,
                                           input rqtype_e rqtype, input amo_op_e amo,
                                           input logic ifetch);
        chan_req_t r;
        r.addr   = addr;
        r.data   = data;
        r.size   = size;
        r.rqtype = rqtype;
        r.amo_op = amo;
        // top two bits of the cache index
        if (ifetch) begin
            r.way = addr[IC_OFFSET_W+IC_INDEX_W-1 -: 2];
        end else begin
            r.way = addr[DC_OFFSET_W+DC_INDEX_W-1 -: 2];
        end
        return r;
    endfunction

    // L1.5 model that waits for a request, checks it and holds off the ack
    task automatic serve_request(input string test, input chan_req_t exp, input int hold);
        int waited;
        waited = 0;
        while (!l15_req_val_o && waited < REQ_WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        assert (l15_req_val_o) else begin
            errors++;
            $display("%s: bridge raised no request within %0d cycles", test, REQ_WAIT_MAX);
        end
        if (l15_req_val_o) begin
            check_vec(test, "request", CW'(exp), CW'(l15_req_o));
            check_bit(test, "nc bit", exp.addr[PADDR_W-1], l15_nc_o);
            repeat (hold) begin
                @(negedge clk);
                check_bit(test, "valid held", 1'b1, l15_req_val_o);
                check_vec(test, "request held", CW'(exp), CW'(l15_req_o));
            end
            l15_ack_i = 1'b1;
            @(negedge clk);
            l15_ack_i = 1'b0;
            check_bit(test, "valid after ack", 1'b0, l15_req_val_o);
        end
    endtask

    task automatic start_return(input string test, input rettype_e rt,
                                input logic [PADDR_W-1:0] addr,
                                input logic [3:0][DATA_W-1:0] words);
        l15_ret_i.val     = 1'b1;
        l15_ret_i.rettype = rt;
        l15_ret_i.addr    = addr;
        l15_ret_i.data    = words;
        #1;
        check_bit(test, "return ack", 1'b1, l15_ret_ack_o);
    endtask

    task automatic finish_return();
        @(negedge clk);
        l15_ret_i = '0;
    endtask

    task automatic test_reset();
        check_bit("reset", "req valid", 1'b0, l15_req_val_o);
        check_bit("reset", "int", 1'b0, int_o);
        check_bit("reset", "store stall", 1'b0, dc_st_stall_o);
        check_bit("reset", "store complete", 1'b0, dc_st_complete_o);
        check_bit("reset", "ic fill valid", 1'b0, ic_fill_o.valid);
        check_bit("reset", "dc fill valid", 1'b0, dc_fill_o.valid);
    endtask

    task automatic test_ifill();
        logic [IC_BLK_W-1:0]    blk;
        logic [PADDR_W-1:0]     addr;
        logic [3:0][DATA_W-1:0] words;
        ic_fill_t               exp_fill;
        blk = 35'h4_a5c3_19e7;
        addr = {blk, {IC_OFFSET_W{1'b0}}};
        ic_req_addr_i = blk;
        ic_req_valid_i = 1'b1;
        @(negedge clk);
        ic_req_valid_i = 1'b0;
        check_bit("ifill", "valid after 1 cycle", 1'b0, l15_req_val_o);
        @(negedge clk);
        check_bit("ifill", "valid after 2 cycles", 1'b1, l15_req_val_o);
        serve_request("ifill", make_req(addr, '0, SZ_4B, IMISS_RQ, AMO_NONE, 1'b1), 3);
        for (int w = 0; w < 4; w++) begin
            words[w] = rand_word();
        end
        start_return("ifill", IFILL_RET, addr, words);
        exp_fill.valid = 1'b1;
        exp_fill.tag   = addr[PADDR_W-1 -: IC_TAG_W];
        exp_fill.index = addr[IC_OFFSET_W +: IC_INDEX_W];
        exp_fill.line  = {swap_bytes(words[3]), swap_bytes(words[2]),
                          swap_bytes(words[1]), swap_bytes(words[0])};
        check_vec("ifill", "ic fill", CW'(exp_fill), CW'(ic_fill_o));
        check_bit("ifill", "dc fill valid", 1'b0, dc_fill_o.valid);
        check_bit("ifill", "store complete", 1'b0, dc_st_complete_o);
        finish_return();
    endtask

    task automatic run_load(input string test, input logic [DC_BLK_W-1:0] blk,
                            input logic reserve, input rettype_e rt);
        logic [PADDR_W-1:0]     addr;
        logic [3:0][DATA_W-1:0] words;
        dc_fill_t               exp_fill;
        addr = {blk, {DC_OFFSET_W{1'b0}}};
        dc_ld_addr_i = blk;
        dc_ld_reserve_i = reserve;
        dc_ld_valid_i = 1'b1;
        @(negedge clk);
        dc_ld_valid_i = 1'b0;
        dc_ld_reserve_i = 1'b0;
        serve_request(test, make_req(addr, '0, SZ_16B, reserve ? SWAP_RQ : LOAD_RQ,
                                     reserve ? AMO_LR : AMO_NONE, 1'b0), 1);
        for (int w = 0; w < 4; w++) begin
            words[w] = rand_word();
        end
        start_return(test, rt, addr, words);
        exp_fill.valid = 1'b1;
        exp_fill.tag   = addr[PADDR_W-1 -: DC_TAG_W];
        exp_fill.index = addr[DC_OFFSET_W +: DC_INDEX_W];
        exp_fill.line  = {swap_bytes(words[1]), swap_bytes(words[0])};
        check_vec(test, "dc fill", CW'(exp_fill), CW'(dc_fill_o));
        check_bit(test, "ic fill valid", 1'b0, ic_fill_o.valid);
        check_bit(test, "store complete", 1'b0, dc_st_complete_o);
        finish_return();
    endtask

    task automatic run_store(input string test, input logic [PADDR_W-1:0] addr,
                             input size_e size, input logic cond, input rettype_e rt);
        logic [DATA_W-1:0] data;
        data = rand_word();
        dc_st_addr_i = addr;
        dc_st_data_i = data;
        dc_st_size_i = size;
        dc_st_cond_i = cond;
        dc_st_valid_i = 1'b1;
        #1;
        check_bit(test, "stall on request", 1'b1, dc_st_stall_o);
        @(negedge clk);
        dc_st_valid_i = 1'b0;
        dc_st_cond_i = 1'b0;
        check_bit(test, "stall while pending", 1'b1, dc_st_stall_o);
        serve_request(test, make_req(addr, swap_bytes(data), size, cond ? SWAP_RQ : STORE_RQ,
                                     cond ? AMO_SC : AMO_NONE, 1'b0), 2);
        check_bit(test, "stall after ack", 1'b1, dc_st_stall_o);
        start_return(test, rt, addr, '0);
        check_bit(test, "store complete", 1'b1, dc_st_complete_o);
        check_bit(test, "stall on completion", 1'b1, dc_st_stall_o);
        check_bit(test, "dc fill valid", 1'b0, dc_fill_o.valid);
        check_bit(test, "ic fill valid", 1'b0, ic_fill_o.valid);
        finish_return();
        check_bit(test, "stall released", 1'b0, dc_st_stall_o);
    endtask

    task automatic test_priority();
        logic [DATA_W-1:0] data;
        data = rand_word();
        ic_req_addr_i = 35'h0_0001_2345;
        ic_req_valid_i = 1'b1;
        dc_ld_addr_i = 36'h0_0abc_d120;
        dc_ld_reserve_i = 1'b0;
        dc_ld_valid_i = 1'b1;
        dc_st_addr_i = 40'h00_2000_0408;
        dc_st_data_i = data;
        dc_st_size_i = SZ_2B;
        dc_st_cond_i = 1'b0;
        dc_st_valid_i = 1'b1;
        @(negedge clk);
        ic_req_valid_i = 1'b0;
        dc_ld_valid_i = 1'b0;
        dc_st_valid_i = 1'b0;
        serve_request("priority", make_req({35'h0_0001_2345, {IC_OFFSET_W{1'b0}}}, '0, SZ_4B,
                                           IMISS_RQ, AMO_NONE, 1'b1), 2);
        @(negedge clk);
        check_bit("priority", "load 2 cycles after ack", 1'b1, l15_req_val_o);
        serve_request("priority", make_req({36'h0_0abc_d120, {DC_OFFSET_W{1'b0}}}, '0, SZ_16B,
                                           LOAD_RQ, AMO_NONE, 1'b0), 3);
        @(negedge clk);
        check_bit("priority", "store 2 cycles after ack", 1'b1, l15_req_val_o);
        serve_request("priority", make_req(40'h00_2000_0408, swap_bytes(data), SZ_2B,
                                           STORE_RQ, AMO_NONE, 1'b0), 1);
        // release the store stall
        start_return("priority", ST_ACK, 40'h00_2000_0408, '0);
        finish_return();
    endtask

    task automatic test_interrupt();
        logic [3:0][DATA_W-1:0] words;
        for (int w = 0; w < 4; w++) begin
            words[w] = rand_word();
        end
        start_return("interrupt", INT_RET, '0, words);
        check_bit("interrupt", "int on return cycle", 1'b0, int_o);
        check_bit("interrupt", "ic fill valid", 1'b0, ic_fill_o.valid);
        check_bit("interrupt", "dc fill valid", 1'b0, dc_fill_o.valid);
        check_bit("interrupt", "store complete", 1'b0, dc_st_complete_o);
        finish_return();
        check_bit("interrupt", "int pulse", 1'b1, int_o);
        @(negedge clk);
        check_bit("interrupt", "int pulse length", 1'b0, int_o);
    endtask

    initial begin
        seed = 32'haef2_8dd5;
        errors = 0;
        checks = 0;
        clk = 1'b0;
        rst_n = 1'b0;
        ic_req_addr_i = '0;
        ic_req_valid_i = 1'b0;
        dc_ld_addr_i = '0;
        dc_ld_reserve_i = 1'b0;
        dc_ld_valid_i = 1'b0;
        dc_st_addr_i = '0;
        dc_st_data_i = '0;
        dc_st_size_i = SZ_1B;
        dc_st_cond_i = 1'b0;
        dc_st_valid_i = 1'b0;
        l15_ack_i = 1'b0;
        l15_ret_i = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_ifill();
        // reserved load first so the load slot ends up holding a plain load
        run_load("load_lr", 36'h8_7654_3b20, 1'b1, ATOMIC_RET);
        run_load("load", 36'h0_1234_5a6c, 1'b0, LOAD_RET);
        run_store("store", 40'h12_3456_7c88, SZ_8B, 1'b0, ST_ACK);
        run_store("store_sc", 40'h91_0a0b_0c40, SZ_4B, 1'b1, ATOMIC_RET);
        test_priority();
        test_interrupt();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: build.f
rtl/l15_bridge_pkg.sv
rtl/req_capture.sv
rtl/req_slot.sv
rtl/req_issue.sv
rtl/resp_decode.sv
rtl/l15_bridge_top.sv
tests/tb_l15_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l15_bridge
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
